// File: compile.f
design/ic_pkg.sv
design/ic_rr_arbiter.sv
design/ic_master_port.sv
design/ic_sram_slave.sv
design/ic_interconnect_2x2.sv
design/ic_subsystem_top.sv
verification/ic_tb_assertions.sv
verification/ic_tb.sv

// File: design/ic_interconnect_2x2.sv
//////////////////////////////////////////////////
// 2x2 interconnect: master ports, request and
// response arbiters, ID-based response routing
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ic_interconnect_2x2 (
	input  logic           clk,
	input  logic           arst_n,
	input  ic_pkg::m_req_t m0_req,
	input  logic           m0_req_valid,
	output logic           m0_req_ready,
	output ic_pkg::m_rsp_t m0_rsp,
	output logic           m0_rsp_valid,
	input  logic           m0_rsp_ready,
	input  ic_pkg::m_req_t m1_req,
	input  logic           m1_req_valid,
	output logic           m1_req_ready,
	output ic_pkg::m_rsp_t m1_rsp,
	output logic           m1_rsp_valid,
	input  logic           m1_rsp_ready,
	output ic_pkg::s_req_t s0_req,
	output logic           s0_req_valid,
	input  logic           s0_req_ready,
	input  ic_pkg::s_rsp_t s0_rsp,
	input  logic           s0_rsp_valid,
	output logic           s0_rsp_ready,
	output ic_pkg::s_req_t s1_req,
	output logic           s1_req_valid,
	input  logic           s1_req_ready,
	input  ic_pkg::s_rsp_t s1_rsp,
	input  logic           s1_rsp_valid,
	output logic           s1_rsp_ready
);

	// Master k to slave j request channels
	ic_pkg::s_req_t m0_s0_req, m0_s1_req, m1_s0_req, m1_s1_req;
	logic m0_s0_valid, m0_s1_valid, m1_s0_valid, m1_s1_valid;
	logic m0_s0_ready, m0_s1_ready, m1_s0_ready, m1_s1_ready;

	// Slave j to master k response candidates
	logic s0_m0_valid, s0_m1_valid, s1_m0_valid, s1_m1_valid;
	logic s0_m0_ready, s0_m1_ready, s1_m0_ready, s1_m1_ready;

	// Arbitrated responses into each master port
	ic_pkg::s_rsp_t m0_s_rsp, m1_s_rsp;
	logic m0_s_rsp_valid, m1_s_rsp_valid;
	logic m0_s_rsp_ready, m1_s_rsp_ready;

	//////////////////////////////////////////////////
	// Master ports
	//////////////////////////////////////////////////

	ic_master_port u_mp0 (
		.clk(clk), .arst_n(arst_n), .master_idx(1'b0),
		.req(m0_req), .req_valid(m0_req_valid), .req_ready(m0_req_ready),
		.rsp(m0_rsp), .rsp_valid(m0_rsp_valid), .rsp_ready(m0_rsp_ready),
		.s_req0(m0_s0_req), .s_req0_valid(m0_s0_valid), .s_req0_ready(m0_s0_ready),
		.s_req1(m0_s1_req), .s_req1_valid(m0_s1_valid), .s_req1_ready(m0_s1_ready),
		.s_rsp(m0_s_rsp), .s_rsp_valid(m0_s_rsp_valid), .s_rsp_ready(m0_s_rsp_ready)
	);

	ic_master_port u_mp1 (
		.clk(clk), .arst_n(arst_n), .master_idx(1'b1),
		.req(m1_req), .req_valid(m1_req_valid), .req_ready(m1_req_ready),
		.rsp(m1_rsp), .rsp_valid(m1_rsp_valid), .rsp_ready(m1_rsp_ready),
		.s_req0(m1_s0_req), .s_req0_valid(m1_s0_valid), .s_req0_ready(m1_s0_ready),
		.s_req1(m1_s1_req), .s_req1_valid(m1_s1_valid), .s_req1_ready(m1_s1_ready),
		.s_rsp(m1_s_rsp), .s_rsp_valid(m1_s_rsp_valid), .s_rsp_ready(m1_s_rsp_ready)
	);

	//////////////////////////////////////////////////
	// Request arbiters, one per slave
	//////////////////////////////////////////////////

	ic_rr_arbiter #(.payload_t(ic_pkg::s_req_t)) u_req_arb0 (
		.clk(clk), .arst_n(arst_n),
		.in0(m0_s0_req), .in0_valid(m0_s0_valid), .in0_ready(m0_s0_ready),
		.in1(m1_s0_req), .in1_valid(m1_s0_valid), .in1_ready(m1_s0_ready),
		.out(s0_req), .out_valid(s0_req_valid), .out_ready(s0_req_ready)
	);

	ic_rr_arbiter #(.payload_t(ic_pkg::s_req_t)) u_req_arb1 (
		.clk(clk), .arst_n(arst_n),
		.in0(m0_s1_req), .in0_valid(m0_s1_valid), .in0_ready(m0_s1_ready),
		.in1(m1_s1_req), .in1_valid(m1_s1_valid), .in1_ready(m1_s1_ready),
		.out(s1_req), .out_valid(s1_req_valid), .out_ready(s1_req_ready)
	);

	//////////////////////////////////////////////////
	// Response split on the master index bit
	//////////////////////////////////////////////////

	assign s0_m0_valid  = s0_rsp_valid && !s0_rsp.id[ic_pkg::MID_W];
	assign s0_m1_valid  = s0_rsp_valid && s0_rsp.id[ic_pkg::MID_W];
	assign s1_m0_valid  = s1_rsp_valid && !s1_rsp.id[ic_pkg::MID_W];
	assign s1_m1_valid  = s1_rsp_valid && s1_rsp.id[ic_pkg::MID_W];
	assign s0_rsp_ready = s0_rsp.id[ic_pkg::MID_W] ? s0_m1_ready : s0_m0_ready;
	assign s1_rsp_ready = s1_rsp.id[ic_pkg::MID_W] ? s1_m1_ready : s1_m0_ready;

	// Response arbiters, one per master
	ic_rr_arbiter #(.payload_t(ic_pkg::s_rsp_t)) u_rsp_arb0 (
		.clk(clk), .arst_n(arst_n),
		.in0(s0_rsp), .in0_valid(s0_m0_valid), .in0_ready(s0_m0_ready),
		.in1(s1_rsp), .in1_valid(s1_m0_valid), .in1_ready(s1_m0_ready),
		.out(m0_s_rsp), .out_valid(m0_s_rsp_valid), .out_ready(m0_s_rsp_ready)
	);

	ic_rr_arbiter #(.payload_t(ic_pkg::s_rsp_t)) u_rsp_arb1 (
		.clk(clk), .arst_n(arst_n),
		.in0(s0_rsp), .in0_valid(s0_m1_valid), .in0_ready(s0_m1_ready),
		.in1(s1_rsp), .in1_valid(s1_m1_valid), .in1_ready(s1_m1_ready),
		.out(m1_s_rsp), .out_valid(m1_s_rsp_valid), .out_ready(m1_s_rsp_ready)
	);

endmodule

// File: design/ic_master_port.sv
//////////////////////////////////////////////////
// Master port: address decode, ID widening and
// local decode-error responses
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ic_master_port (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           master_idx,
	input  ic_pkg::m_req_t req,
	input  logic           req_valid,
	output logic           req_ready,
	output ic_pkg::m_rsp_t rsp,
	output logic           rsp_valid,
	input  logic           rsp_ready,
	output ic_pkg::s_req_t s_req0,
	output logic           s_req0_valid,
	input  logic           s_req0_ready,
	output ic_pkg::s_req_t s_req1,
	output logic           s_req1_valid,
	input  logic           s_req1_ready,
	input  ic_pkg::s_rsp_t s_rsp,
	input  logic           s_rsp_valid,
	output logic           s_rsp_ready
);

	logic                     hit0;
	logic                     hit1;
	logic                     err_accept;
	logic                     err_valid;  // Decode error waiting for the master
	logic [ic_pkg::MID_W-1:0] err_id;
	logic                     lock_q;     // Slave response shown and stalled
	logic                     sel_err;
	ic_pkg::s_req_t           fwd;

	assign hit0 = (req.addr >= ic_pkg::S0_BASE) && (req.addr <= ic_pkg::S0_LIMIT);
	assign hit1 = (req.addr >= ic_pkg::S1_BASE) && (req.addr <= ic_pkg::S1_LIMIT);

	always_comb begin
		fwd.addr  = req.addr;
		fwd.wdata = req.wdata;
		fwd.write = req.write;
		fwd.id    = {master_idx, req.id};
	end

	assign s_req0       = fwd;
	assign s_req1       = fwd;
	assign s_req0_valid = req_valid && hit0 && !err_valid;
	assign s_req1_valid = req_valid && hit1 && !err_valid;

	always_comb begin
		if (err_valid)
			req_ready = 1'b0;          // Stall until the error is taken
		else if (hit0)
			req_ready = s_req0_ready;
		else if (hit1)
			req_ready = s_req1_ready;
		else
			req_ready = 1'b1;          // Unmapped, absorbed here
	end

	assign err_accept = req_valid && req_ready && !hit0 && !hit1;

	// Error wins unless a slave response is already on display
	assign sel_err     = err_valid && !lock_q;
	assign rsp_valid   = err_valid || s_rsp_valid;
	assign s_rsp_ready = rsp_ready && !sel_err;

	always_comb begin
		if (sel_err) begin
			rsp.rdata = '0;
			rsp.id    = err_id;
			rsp.err   = 1'b1;
		end else begin
			rsp.rdata = s_rsp.rdata;
			rsp.id    = s_rsp.id[ic_pkg::MID_W-1:0];  // Drop master index
			rsp.err   = s_rsp.err;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			err_valid <= 1'b0;
			lock_q    <= 1'b0;
		end else begin
			if (err_accept)
				err_valid <= 1'b1;
			else if (sel_err && rsp_ready)
				err_valid <= 1'b0;
			lock_q <= s_rsp_valid && !sel_err && !rsp_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (err_accept)
			err_id <= req.id;
	end

endmodule

// File: design/ic_pkg.sv
//////////////////////////////////////////////////
// Interconnect widths, address map and the
// request/response structs of both bus sides
//////////////////////////////////////////////////

package ic_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int MID_W     = 4;           // ID as seen by a master
	localparam int SID_W     = MID_W + 1;   // Master index appended on top
	localparam int MEM_WORDS = 1024;
	localparam int MEM_AW    = $clog2(MEM_WORDS);

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////

	localparam logic [ADDR_W-1:0] S0_BASE  = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] S0_LIMIT = 32'h0000_0fff;
	localparam logic [ADDR_W-1:0] S1_BASE  = 32'h0000_1000;
	localparam logic [ADDR_W-1:0] S1_LIMIT = 32'h0000_1fff;

	//////////////////////////////////////////////////
	// Channel payloads
	//////////////////////////////////////////////////

	// Master side request
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              write;
		logic [MID_W-1:0]  id;
	} m_req_t;

	// Master side response
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic [MID_W-1:0]  id;
		logic              err;
	} m_rsp_t;

	// Slave side request, id MSB is the master index
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              write;
		logic [SID_W-1:0]  id;
	} s_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic [SID_W-1:0]  id;
		logic              err;
	} s_rsp_t;

endpackage

// File: design/ic_rr_arbiter.sv
//////////////////////////////////////////////////
// Two-input round-robin arbiter, any payload type
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ic_rr_arbiter #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t in0,
	input  logic     in0_valid,
	output logic     in0_ready,
	input  payload_t in1,
	input  logic     in1_valid,
	output logic     in1_ready,
	output payload_t out,
	output logic     out_valid,
	input  logic     out_ready
);

	logic prio_q;      // 0 favors in0, 1 favors in1
	logic hold_q;      // Output stalled last cycle
	logic hold_sel_q;
	logic rr_sel;
	logic sel;         // 1 selects in1
	logic xfer;

	//////////////////////////////////////////////////
	// Grant
	//////////////////////////////////////////////////

	always_comb begin
		if (in0_valid && in1_valid)
			rr_sel = prio_q;
		else
			rr_sel = in1_valid;
	end

	// A stalled output keeps its grant so the payload stays put
	assign sel = hold_q ? hold_sel_q : rr_sel;

	assign out       = sel ? in1 : in0;
	assign out_valid = in0_valid || in1_valid;
	assign in0_ready = out_ready && !sel;
	assign in1_ready = out_ready && sel;
	assign xfer      = out_valid && out_ready;

	//////////////////////////////////////////////////
	// Priority and hold state
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prio_q     <= 1'b0;
			hold_q     <= 1'b0;
			hold_sel_q <= 1'b0;
		end else begin
			if (xfer)
				prio_q <= !sel;  // Winner drops to low priority
			hold_q     <= out_valid && !out_ready;
			hold_sel_q <= sel;
		end
	end

endmodule

// File: design/ic_sram_slave.sv
//////////////////////////////////////////////////
// Single-port SRAM slave with one-entry
// response register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ic_sram_slave (
	input  logic           clk,
	input  logic           arst_n,
	input  ic_pkg::s_req_t req,
	input  logic           req_valid,
	output logic           req_ready,
	output ic_pkg::s_rsp_t rsp,
	output logic           rsp_valid,
	input  logic           rsp_ready
);

	logic [ic_pkg::DATA_W-1:0] mem [ic_pkg::MEM_WORDS];
	logic [ic_pkg::MEM_AW-1:0] idx;
	logic                      accept;
	logic                      rsp_valid_q;
	ic_pkg::s_rsp_t            rsp_q;

	// Word index from address bits 11:2
	assign idx = req.addr[ic_pkg::MEM_AW+1:2];

	// Free slot, or the held one leaves this cycle
	assign req_ready = !rsp_valid_q || rsp_ready;
	assign accept    = req_valid && req_ready;

	assign rsp       = rsp_q;
	assign rsp_valid = rsp_valid_q;

	//////////////////////////////////////////////////
	// Storage and response payload
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			if (req.write) begin
				mem[idx]    <= req.wdata;
				rsp_q.rdata <= '0;
			end else begin
				rsp_q.rdata <= mem[idx];
			end
			rsp_q.id  <= req.id;   // Echo, master index included
			rsp_q.err <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Response valid
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid_q <= 1'b0;
		end else begin
			if (accept)
				rsp_valid_q <= 1'b1;
			else if (rsp_ready)
				rsp_valid_q <= 1'b0;
		end
	end

endmodule

// File: design/ic_subsystem_top.sv
//////////////////////////////////////////////////
// Subsystem top: 2x2 interconnect and two SRAMs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ic_subsystem_top (
	input  logic           clk,
	input  logic           arst_n,
	input  ic_pkg::m_req_t m0_req,
	input  logic           m0_req_valid,
	output logic           m0_req_ready,
	output ic_pkg::m_rsp_t m0_rsp,
	output logic           m0_rsp_valid,
	input  logic           m0_rsp_ready,
	input  ic_pkg::m_req_t m1_req,
	input  logic           m1_req_valid,
	output logic           m1_req_ready,
	output ic_pkg::m_rsp_t m1_rsp,
	output logic           m1_rsp_valid,
	input  logic           m1_rsp_ready
);

	ic_pkg::s_req_t s0_req, s1_req;
	ic_pkg::s_rsp_t s0_rsp, s1_rsp;
	logic s0_req_valid, s0_req_ready, s0_rsp_valid, s0_rsp_ready;
	logic s1_req_valid, s1_req_ready, s1_rsp_valid, s1_rsp_ready;

	ic_interconnect_2x2 u_ic (
		.clk(clk), .arst_n(arst_n),
		.m0_req(m0_req), .m0_req_valid(m0_req_valid), .m0_req_ready(m0_req_ready),
		.m0_rsp(m0_rsp), .m0_rsp_valid(m0_rsp_valid), .m0_rsp_ready(m0_rsp_ready),
		.m1_req(m1_req), .m1_req_valid(m1_req_valid), .m1_req_ready(m1_req_ready),
		.m1_rsp(m1_rsp), .m1_rsp_valid(m1_rsp_valid), .m1_rsp_ready(m1_rsp_ready),
		.s0_req(s0_req), .s0_req_valid(s0_req_valid), .s0_req_ready(s0_req_ready),
		.s0_rsp(s0_rsp), .s0_rsp_valid(s0_rsp_valid), .s0_rsp_ready(s0_rsp_ready),
		.s1_req(s1_req), .s1_req_valid(s1_req_valid), .s1_req_ready(s1_req_ready),
		.s1_rsp(s1_rsp), .s1_rsp_valid(s1_rsp_valid), .s1_rsp_ready(s1_rsp_ready)
	);

	// Slave 0 at 0x0000
	ic_sram_slave u_sram0 (
		.clk(clk), .arst_n(arst_n),
		.req(s0_req), .req_valid(s0_req_valid), .req_ready(s0_req_ready),
		.rsp(s0_rsp), .rsp_valid(s0_rsp_valid), .rsp_ready(s0_rsp_ready)
	);

	// Slave 1 at 0x1000
	ic_sram_slave u_sram1 (
		.clk(clk), .arst_n(arst_n),
		.req(s1_req), .req_valid(s1_req_valid), .req_ready(s1_req_ready),
		.rsp(s1_rsp), .rsp_valid(s1_rsp_valid), .rsp_ready(s1_rsp_ready)
	);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module ic_tb

status=0
./obj_dir/Vic_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation finished cleanly"

// File: verification/ic_tb.sv
//////////////////////////////////////////////////
// Testbench for the 2x2 subsystem: drivers, shadow
// memory, reference model and response compare
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ic_tb;

	localparam logic [31:0] SEED       = 32'h7aab_7fd9;
	localparam int          N_DIRECTED = 7;
	localparam int          N_RANDOM   = 200;
	localparam int          TIMEOUT    = 40 * 2 * (N_DIRECTED + N_RANDOM) + 16;

	logic           clk;
	logic           arst_n;
	ic_pkg::m_req_t req [2];
	logic           req_valid [2];
	logic           req_ready [2];
	ic_pkg::m_rsp_t rsp [2];
	logic           rsp_valid [2];
	logic           rsp_ready [2];

	ic_pkg::m_rsp_t exp_rsp [2];                    // Expected reply per master
	int             issued [2]   = '{0, 0};
	int             returned [2] = '{0, 0};
	int             err_count    = 0;
	int             cycles       = 0;
	logic [31:0]    shadow [2048] = '{default: '0};  // Both slaves with the slave bit on top
	logic           written [2048] = '{default: 1'b0};

	ic_subsystem_top uut (
		.clk(clk), .arst_n(arst_n),
		.m0_req(req[0]), .m0_req_valid(req_valid[0]), .m0_req_ready(req_ready[0]),
		.m0_rsp(rsp[0]), .m0_rsp_valid(rsp_valid[0]), .m0_rsp_ready(rsp_ready[0]),
		.m1_req(req[1]), .m1_req_valid(req_valid[1]), .m1_req_ready(req_ready[1]),
		.m1_rsp(rsp[1]), .m1_rsp_valid(rsp_valid[1]), .m1_rsp_ready(rsp_ready[1])
	);

	bind ic_subsystem_top ic_tb_assertions u_assert (
		.clk(clk), .arst_n(arst_n),
		.m0_req(m0_req), .m0_req_valid(m0_req_valid), .m0_req_ready(m0_req_ready),
		.m0_rsp(m0_rsp), .m0_rsp_valid(m0_rsp_valid), .m0_rsp_ready(m0_rsp_ready),
		.m1_req(m1_req), .m1_req_valid(m1_req_valid), .m1_req_ready(m1_req_ready),
		.m1_rsp(m1_rsp), .m1_rsp_valid(m1_rsp_valid), .m1_rsp_ready(m1_rsp_ready)
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic in_win(input logic [31:0] a, input logic [31:0] base,
			input logic [31:0] limit);
		return (a - base) <= (limit - base);  // Offset form that wraps below base
	endfunction

	function automatic logic in_map(input logic [31:0] a);
		return in_win(a, ic_pkg::S0_BASE, ic_pkg::S0_LIMIT) ||
			in_win(a, ic_pkg::S1_BASE, ic_pkg::S1_LIMIT);
	endfunction

	function automatic logic [10:0] word_idx(input logic [31:0] a);
		return {in_win(a, ic_pkg::S1_BASE, ic_pkg::S1_LIMIT), a[11:2]};
	endfunction

	function automatic ic_pkg::m_rsp_t model_rsp(input logic [31:0] a, input logic write,
			input logic [3:0] id, input logic [31:0] mem [2048]);
		ic_pkg::m_rsp_t r;
		r.id    = id;
		r.err   = !in_map(a);
		r.rdata = '0;                          // Writes and errors return zero
		if (in_map(a) && !write)
			r.rdata = mem[word_idx(a)];
		return r;
	endfunction

	task automatic compare_vals(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first error");
		end
	endtask

	//////////////////////////////////////////////////
	// Master drivers
	//////////////////////////////////////////////////

	// One transaction that waits for its response
	task automatic send_req(input logic k, input logic [31:0] a, input logic write,
			input logic [31:0] wdata, input logic [3:0] id);
		ic_pkg::m_req_t r;
		r.addr  = a;
		r.wdata = wdata;
		r.write = write;
		r.id    = id;
		req[k]       <= r;
		req_valid[k] <= 1'b1;
		do
			@(posedge clk);
		while (!req_ready[k]);
		exp_rsp[k] = model_rsp(a, write, id, shadow);
		if (write && in_map(a)) begin
			shadow[word_idx(a)]  = wdata;
			written[word_idx(a)] = 1'b1;
		end
		issued[k]    = issued[k] + 1;
		req_valid[k] <= 1'b0;
		wait (returned[k] == issued[k]);
		@(posedge clk);
	endtask

	task automatic run_master(input logic k);
		logic [31:0] st;
		logic [31:0] a;
		logic [31:0] base;
		logic        wr;
		st   = next_rand(SEED ^ {31'd0, k});
		base = {29'd0, k, 2'b00};             // Word parity follows the master
		// Both masters start on slave 0 together
		send_req(k, base, 1'b1, 32'ha5a5_0000 | base, 4'h1);
		send_req(k, base | 32'h1000, 1'b1, 32'h5a5a_1000 | base, 4'h2);
		send_req(k, base, 1'b0, '0, 4'h3);
		send_req(k, base | 32'h1000, 1'b0, '0, 4'h4);
		// Unmapped write must leave the SRAM alone
		a = k ? 32'hffff_0004 : 32'h0000_2000;
		send_req(k, a, 1'b1, 32'hdead_beef, 4'h5);
		send_req(k, a, 1'b0, '0, 4'h6);
		send_req(k, base, 1'b0, '0, 4'h7);
		repeat (N_RANDOM) begin
			st = next_rand(st);
			a  = {19'd0, st[8], st[17:9], k, 2'b00};
			if (st[2:0] == 3'd0)
				a = {st[31:2], 2'b00} | 32'h0000_2000;  // Error region
			wr = st[3];
			if (!wr && in_map(a) && !written[word_idx(a)])
				wr = 1'b1;                             // No reads of unknown words
			send_req(k, a, wr, next_rand(st ^ 32'h1357_9bdf), st[7:4]);
		end
	endtask

	//////////////////////////////////////////////////
	// Clock, reset, back-pressure
	//////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin : back_pressure
		logic [31:0] st;
		logic [3:0]  left0;
		logic [3:0]  left1;
		st           = SEED ^ 32'h0000_ffff;
		left0        = 4'd0;
		left1        = 4'd0;
		rsp_ready[0] <= 1'b1;
		rsp_ready[1] <= 1'b1;
		forever begin
			@(posedge clk);
			st = next_rand(st);
			if (left0 == 4'd0) begin
				rsp_ready[0] <= st[31:30] != 2'b00;   // Low about a quarter of stretches
				left0 = st[7:4];
			end else begin
				left0 = left0 - 4'd1;
			end
			if (left1 == 4'd0) begin
				rsp_ready[1] <= st[29:28] != 2'b00;
				left1 = st[11:8];
			end else begin
				left1 = left1 - 4'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Response compare and timeout
	//////////////////////////////////////////////////

	task automatic take_rsp(input logic k);
		if (rsp_valid[k] && rsp_ready[k]) begin
			if (returned[k] == issued[k]) begin
				$display("ERROR at %0t: master %0d got a response with no request outstanding",
					$time, k);
				$display("*** TEST FAILED ***");
				$fatal(1, "unexpected response");
			end else begin
				compare_vals(64'(rsp[k]), 64'(exp_rsp[k]),
					$sformatf("master %0d response id %h", k, exp_rsp[k].id));
				returned[k] = returned[k] + 1;
			end
		end
	endtask

	always @(posedge clk) begin
		take_rsp(1'b0);
		take_rsp(1'b1);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("ERROR at %0t: timeout after %0d cycles, a transaction never finished",
				$time, cycles);
			$display("*** TEST FAILED ***");
			$fatal(1, "timeout");
		end
	end

	initial begin
		arst_n       <= 1'b0;
		req[0]       <= '0;
		req[1]       <= '0;
		req_valid[0] <= 1'b0;
		req_valid[1] <= 1'b0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		fork
			run_master(1'b0);
			run_master(1'b1);
		join
		repeat (4) @(posedge clk);
		if (err_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "errors found");
		end
	end

endmodule

// File: verification/ic_tb_assertions.sv
//////////////////////////////////////////////////
// Handshake stability and reset checks on the
// four top-level channels
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ic_tb_assertions (
	input logic           clk,
	input logic           arst_n,
	input ic_pkg::m_req_t m0_req,
	input logic           m0_req_valid,
	input logic           m0_req_ready,
	input ic_pkg::m_rsp_t m0_rsp,
	input logic           m0_rsp_valid,
	input logic           m0_rsp_ready,
	input ic_pkg::m_req_t m1_req,
	input logic           m1_req_valid,
	input logic           m1_req_ready,
	input ic_pkg::m_rsp_t m1_rsp,
	input logic           m1_rsp_valid,
	input logic           m1_rsp_ready
);

	// Stalled channels keep valid and payload
	m0_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		m0_req_valid && !m0_req_ready |=> m0_req_valid && $stable(m0_req))
		else $error("master 0 request changed while stalled");
	m0_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
		m0_rsp_valid && !m0_rsp_ready |=> m0_rsp_valid && $stable(m0_rsp))
		else $error("master 0 response changed while stalled");
	m1_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		m1_req_valid && !m1_req_ready |=> m1_req_valid && $stable(m1_req))
		else $error("master 1 request changed while stalled");
	m1_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
		m1_rsp_valid && !m1_rsp_ready |=> m1_rsp_valid && $stable(m1_rsp))
		else $error("master 1 response changed while stalled");

	// Quiet bus while in reset
	reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !(m0_req_valid || m0_rsp_valid || m1_req_valid || m1_rsp_valid))
		else $error("valid raised during reset");

endmodule
